/* bcd_lab_config.svh */
`ifndef BCD_LAB_CONFIG_SVH
`define BCD_LAB_CONFIG_SVH

////////////////////
// Tick divider
////////////////////

// Width of the free-running divider counter
// Any value of 6 or more works
`define BCD_DIV_WIDTH 32

////////////////////
// Display
////////////////////

// Seven-segment digits on the board
`define BCD_NUM_DIGITS 8

// Refresh step is 2**BCD_SCAN_DIV_LOG2 cycles
// Small for simulation, around 16 on the board
`define BCD_SCAN_DIV_LOG2 4

`endif

/* bcd_lab_pkg.sv */
`default_nettype none

package bcd_lab_pkg;

    ////////////////////
    // Types
    ////////////////////

    typedef logic [3:0] digit_t;

    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_mul = 2'd2,
        op_max = 2'd3
    } alu_op_t;

    // Active low, bit 6 is segment g and bit 0 is segment a
    typedef logic [6:0] seg_t;

    ////////////////////
    // Segment patterns
    ////////////////////

    localparam seg_t seg_digit_table [10] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
        7'h12, 7'h02, 7'h78, 7'h00, 7'h10
    };

    localparam seg_t seg_blank = 7'h7f;
    localparam seg_t seg_minus = 7'h3f;

    // Direction letters
    localparam seg_t seg_up   = 7'h63;
    localparam seg_t seg_down = 7'h21;

    // Operation letters: A, S, P for product, H for the higher digit
    localparam seg_t seg_op_a = 7'h08;
    localparam seg_t seg_op_s = 7'h12;
    localparam seg_t seg_op_p = 7'h0c;
    localparam seg_t seg_op_h = 7'h09;

endpackage

`default_nettype wire

/* tick_divider.sv */
`default_nettype none

`include "bcd_lab_config.svh"

module tick_divider (
    input  logic       clk,
    input  logic       arst_n,
    input  logic [4:0] rate_sel,
    output logic       tick
);

    localparam int div_width = `BCD_DIV_WIDTH;

    logic [div_width-1:0] div_count;
    logic [div_width-1:0] tap_mask;

    ////////////////////
    // Free-running counter
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_count <= '0;
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

    ////////////////////
    // Tap selection
    ////////////////////

    // Low rate_sel+1 bits set
    // saturates at the full counter width
    always_comb begin
        tap_mask = '0;
        for (int i = 0; i < div_width; i++) begin
            if (i <= int'(rate_sel)) begin
                tap_mask[i] = 1'b1;
            end
        end
    end

    // One cycle per period of 2**(rate_sel+1)
    assign tick = ((div_count & tap_mask) == tap_mask);

endmodule

`default_nettype wire

/* bcd_digit_counter.sv */
`default_nettype none

`include "bcd_lab_config.svh"

module bcd_digit_counter
    import bcd_lab_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   tick,
    input  logic   dir,
    output digit_t digit
);

    digit_t digit_up;
    digit_t digit_down;

    // Decimal wrap in both directions
    // out-of-range codes fold back to a legal digit
    always_comb begin
        if (digit >= 4'd9) begin
            digit_up = 4'd0;
        end else begin
            digit_up = digit + 4'd1;
        end

        if ((digit == 4'd0) || (digit > 4'd9)) begin
            digit_down = 4'd9;
        end else begin
            digit_down = digit - 4'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            digit <= 4'd0;
        end else if (tick) begin
            if (dir) begin
                digit <= digit_up;
            end else begin
                digit <= digit_down;
            end
        end
    end

endmodule

`default_nettype wire

/* digit_alu.sv */
`default_nettype none

module digit_alu
    import bcd_lab_pkg::*;
(
    input  digit_t  a,
    input  digit_t  b,
    input  alu_op_t op,
    output digit_t  tens,
    output digit_t  units,
    output logic    negative
);

    logic [6:0] magnitude;

    ////////////////////
    // Arithmetic
    ////////////////////

    // Largest result is 9*9 = 81, fits in 7 bits
    always_comb begin
        magnitude = 7'd0;
        negative  = 1'b0;

        case (op)
            op_add: begin
                magnitude = {3'b000, a} + {3'b000, b};
            end

            op_sub: begin
                if (b > a) begin
                    magnitude = {3'b000, b - a};
                    negative  = 1'b1;
                end else begin
                    magnitude = {3'b000, a - b};
                end
            end

            op_mul: begin
                magnitude = {3'b000, a} * {3'b000, b};
            end

            op_max: begin
                if (a > b) begin
                    magnitude = {3'b000, a};
                end else begin
                    magnitude = {3'b000, b};
                end
            end

            default: begin
                magnitude = 7'd0;
            end
        endcase
    end

    ////////////////////
    // Binary to BCD
    ////////////////////

    // Double dabble over the 7 magnitude bits
    // bits [14:11] end up as tens, [10:7] as units
    always_comb begin
        logic [14:0] dabble;

        dabble = {8'd0, magnitude};

        for (int i = 0; i < 7; i++) begin
            if (dabble[10:7] >= 4'd5) begin
                dabble[10:7] = dabble[10:7] + 4'd3;
            end
            if (dabble[14:11] >= 4'd5) begin
                dabble[14:11] = dabble[14:11] + 4'd3;
            end
            dabble = dabble << 1;
        end

        tens  = dabble[14:11];
        units = dabble[10:7];
    end

endmodule

`default_nettype wire

/* display_scanner.sv */
`default_nettype none

`include "bcd_lab_config.svh"

module display_scanner
    import bcd_lab_pkg::*;
(
    input  logic                         clk,
    input  logic                         arst_n,
    input  digit_t                       digit_a,
    input  digit_t                       digit_b,
    input  digit_t                       tens,
    input  digit_t                       units,
    input  logic                         negative,
    input  logic                         dir_a,
    input  logic                         dir_b,
    input  alu_op_t                      op,
    output seg_t                         seg,
    output logic [`BCD_NUM_DIGITS-1:0]   an
);

    localparam int scan_div_log2 = `BCD_SCAN_DIV_LOG2;
    localparam int num_digits    = `BCD_NUM_DIGITS;

    logic [scan_div_log2-1:0] prescale;
    logic [2:0]               digit_idx;
    seg_t                     seg_next;
    logic [num_digits-1:0]    an_next;

    // Blank for anything that is not a decimal digit
    function automatic seg_t digit_pattern(input digit_t d);
        seg_t pattern;
        if (d <= 4'd9) begin
            pattern = seg_digit_table[d];
        end else begin
            pattern = seg_blank;
        end
        return pattern;
    endfunction

    ////////////////////
    // Refresh prescaler
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prescale  <= '0;
            digit_idx <= 3'd0;
        end else begin
            prescale <= prescale + 1'b1;
            // Step to the next digit when the prescaler rolls over
            if (&prescale) begin
                digit_idx <= digit_idx + 3'd1;
            end
        end
    end

    ////////////////////
    // Digit contents
    ////////////////////

    // Right to left: units, tens, sign, gap, B, A, dir of B, op
    always_comb begin
        case (digit_idx)
            3'd0: seg_next = digit_pattern(units);
            3'd1: seg_next = (tens == 4'd0) ? seg_blank : digit_pattern(tens);
            3'd2: seg_next = negative ? seg_minus : seg_blank;
            3'd3: seg_next = seg_blank;
            3'd4: seg_next = digit_pattern(digit_b);
            3'd5: seg_next = digit_pattern(digit_a);
            3'd6: seg_next = dir_b ? seg_up : seg_down;
            3'd7: begin
                case (op)
                    op_add:  seg_next = seg_op_a;
                    op_sub:  seg_next = seg_op_s;
                    op_mul:  seg_next = seg_op_p;
                    op_max:  seg_next = seg_op_h;
                    default: seg_next = seg_blank;
                endcase
            end
            default: seg_next = seg_blank;
        endcase
    end

    // One-cold anode for the selected position
    always_comb begin
        an_next            = '1;
        an_next[digit_idx] = 1'b0;
    end

    ////////////////////
    // Output registers
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seg <= seg_blank;
            an  <= '1;
        end else begin
            seg <= seg_next;
            an  <= an_next;
        end
    end

endmodule

`default_nettype wire

/* bcd_lab_top.sv */
`default_nettype none

`include "bcd_lab_config.svh"

module bcd_lab_top
    import bcd_lab_pkg::*;
(
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [4:0]                   rate_sel,
    input  alu_op_t                      op,
    input  logic                         dir_a,
    input  logic                         dir_b,
    output seg_t                         seg,
    output logic [`BCD_NUM_DIGITS-1:0]   an,
    output logic [7:0]                   led
);

    logic   tick;
    digit_t digit_a;
    digit_t digit_b;
    digit_t tens;
    digit_t units;
    logic   negative;

    ////////////////////
    // Count enable
    ////////////////////

    tick_divider tick_divider_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rate_sel (rate_sel),
        .tick     (tick)
    );

    ////////////////////
    // Operand digits
    ////////////////////

    bcd_digit_counter counter_a_i (
        .clk    (clk),
        .arst_n (arst_n),
        .tick   (tick),
        .dir    (dir_a),
        .digit  (digit_a)
    );

    bcd_digit_counter counter_b_i (
        .clk    (clk),
        .arst_n (arst_n),
        .tick   (tick),
        .dir    (dir_b),
        .digit  (digit_b)
    );

    // A on the low nibble, B on the high one
    assign led = {digit_b, digit_a};

    ////////////////////
    // Result and display
    ////////////////////

    digit_alu alu_i (
        .a        (digit_a),
        .b        (digit_b),
        .op       (op),
        .tens     (tens),
        .units    (units),
        .negative (negative)
    );

    display_scanner scanner_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .digit_a  (digit_a),
        .digit_b  (digit_b),
        .tens     (tens),
        .units    (units),
        .negative (negative),
        .dir_a    (dir_a),
        .dir_b    (dir_b),
        .op       (op),
        .seg      (seg),
        .an       (an)
    );

endmodule

`default_nettype wire

/* tb_bcd_lab.sv */
`default_nettype none

`include "bcd_lab_config.svh"

module tb_bcd_lab
    import bcd_lab_pkg::*;
();

    localparam int num_digits = `BCD_NUM_DIGITS;
    localparam int div_width  = `BCD_DIV_WIDTH;
    localparam int wait_limit = num_digits * (1 << `BCD_SCAN_DIV_LOG2) + 4;
    // Slow enough that no tick falls inside a display check
    localparam logic [4:0] hold_rate = 5'd20;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic [4:0]            rate_sel;
    logic                  dir_a;
    logic                  dir_b;
    alu_op_t               op;
    seg_t                  seg;
    logic [num_digits-1:0] an;
    logic [7:0]            led;

    // Reference model state
    logic [div_width-1:0]  model_count;
    digit_t                model_a;
    digit_t                model_b;

    int value_errors = 0;
    int other_errors = 0;

    always #10 clk = ~clk;

    bcd_lab_top dut_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rate_sel (rate_sel),
        .op       (op),
        .dir_a    (dir_a),
        .dir_b    (dir_b),
        .seg      (seg),
        .an       (an),
        .led      (led)
    );

    ////////////////////
    // Checking helpers
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s expected %0h got %0h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        other_errors++;
    endtask

    function automatic logic [num_digits-1:0] position_anode(input int pos);
        logic [num_digits-1:0] one_hot;
        one_hot = 1;
        return ~(one_hot << pos);
    endfunction

    ////////////////////
    // Model
    ////////////////////

    function automatic digit_t next_digit(input digit_t d, input logic up);
        if (up)
            return (d == 4'd9) ? 4'd0 : d + 4'd1;
        return (d == 4'd0) ? 4'd9 : d - 4'd1;
    endfunction

    // State after this rising edge, from the inputs the DUT saw at it
    task automatic advance_model();
        logic [div_width-1:0] mask;
        mask = '1;
        mask = ~(mask << (int'(rate_sel) + 1));
        if (!arst_n) begin
            model_count = '0;
            model_a     = 4'd0;
            model_b     = 4'd0;
        end else begin
            if ((model_count & mask) == mask) begin
                model_a = next_digit(model_a, dir_a);
                model_b = next_digit(model_b, dir_b);
            end
            model_count = model_count + 1'b1;
        end
    endtask

    // Pattern each display position should carry
    function automatic seg_t expected_seg(input int pos);
        int result;
        bit neg;
        neg = 1'b0;
        case (op)
            op_add: result = model_a + model_b;
            op_sub: begin
                neg    = (model_b > model_a);
                result = neg ? model_b - model_a : model_a - model_b;
            end
            op_mul:  result = model_a * model_b;
            default: result = (model_a > model_b) ? model_a : model_b;
        endcase
        case (pos)
            0: return seg_digit_table[result % 10];
            1: return (result < 10) ? seg_blank : seg_digit_table[result / 10];
            2: return neg ? seg_minus : seg_blank;
            4: return seg_digit_table[model_b];
            5: return seg_digit_table[model_a];
            6: return dir_b ? seg_up : seg_down;
            7: return (op == op_add) ? seg_op_a : (op == op_sub) ? seg_op_s :
                      (op == op_mul) ? seg_op_p : seg_op_h;
            default: return seg_blank;
        endcase
    endfunction

    ////////////////////
    // Cycle tasks
    ////////////////////

    task automatic run_cycle();
        @(posedge clk);
        advance_model();
        @(negedge clk);
        check_value("led", {model_b, model_a}, led);
    endtask

    task automatic apply_inputs(input logic [4:0] r, input logic da, input logic db,
                                input alu_op_t o);
        @(posedge clk);
        advance_model();
        rate_sel <= r;
        dir_a    <= da;
        dir_b    <= db;
        op       <= o;
        @(negedge clk);
        check_value("led", {model_b, model_a}, led);
    endtask

    task automatic wait_for_position(input int pos, output bit found);
        int count;
        found = 1'b0;
        count = 0;
        while (!found && count < wait_limit) begin
            run_cycle();
            count++;
            found = (an === position_anode(pos));
        end
        assert (found) else
            report_failure($sformatf("Timeout: display position %0d never appeared", pos));
    endtask

    // Leaves the scan at a fixed phase so tick counts per step are known
    task automatic wait_for_scan_start();
        logic [num_digits-1:0] prev;
        int count;
        bit found;
        found = 1'b0;
        count = 0;
        prev  = an;
        while (!found && count < wait_limit) begin
            run_cycle();
            count++;
            found = (an === position_anode(0)) && (prev !== position_anode(0));
            prev  = an;
        end
        assert (found) else
            report_failure("Timeout: the scan never came back to display position 0");
    endtask

    task automatic check_display();
        bit found;
        for (int pos = 0; pos < num_digits; pos++) begin
            wait_for_position(pos, found);
            if (found)
                check_value($sformatf("seg at position %0d", pos), expected_seg(pos), seg);
        end
    endtask

    task automatic check_scan_coverage();
        logic [num_digits-1:0] seen;
        seen = '0;
        repeat (wait_limit) begin
            run_cycle();
            assert ($countones(~an) == 1) else begin
                $display("ERR an is not one-cold, got %0h", an);
                value_errors++;
            end
            seen = seen | ~an;
        end
        for (int pos = 0; pos < num_digits; pos++)
            assert (seen[pos]) else
                report_failure($sformatf("Display position %0d was never selected", pos));
    endtask

    task automatic run_step(input int r, input int da, input int db, input int o,
                            input int cycles, input int exp_a, input int exp_b);
        apply_inputs(r[4:0], da[0], db[0], alu_op_t'(o[1:0]));
        repeat (cycles - 1) run_cycle();
        apply_inputs(hold_rate, dir_a, dir_b, op);
        check_value("led at step end", {exp_b[3:0], exp_a[3:0]}, led);
        check_display();
        wait_for_scan_start();
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int fd;
        int steps;
        string line;
        int t_rate, t_da, t_db, t_op, t_cycles, t_exp_a, t_exp_b;
        arst_n   = 1'b0;
        rate_sel = hold_rate;
        dir_a    = 1'b0;
        dir_b    = 1'b0;
        op       = op_add;
        steps    = 0;

        // Two edges in reset, release driven on the second
        repeat (2) begin
            @(posedge clk);
            advance_model();
            if (steps == 1)
                arst_n <= 1'b1;
            steps++;
            @(negedge clk);
            check_value("an", {num_digits{1'b1}}, an);
            check_value("seg", seg_blank, seg);
            check_value("led", 8'h00, led);
        end
        steps = 0;
        wait_for_scan_start();

        fd = $fopen("bcd_lab_trace.txt", "r");
        if (fd == 0) begin
            report_failure("Could not open the trace file bcd_lab_trace.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%d %d %d %d %d %d %d", t_rate, t_da, t_db, t_op,
                            t_cycles, t_exp_a, t_exp_b) == 7) begin
                    steps++;
                    run_step(t_rate, t_da, t_db, t_op, t_cycles, t_exp_a, t_exp_b);
                end
            end
            $fclose(fd);
            assert (steps > 0) else report_failure("The trace file held no test steps");
        end

        check_scan_coverage();

        $display("Checks done: %0d steps, %0d value errors, %0d other errors",
                 steps, value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
bcd_lab_pkg.sv
tick_divider.sv
bcd_digit_counter.sv
digit_alu.sv
display_scanner.sv
bcd_lab_top.sv
tb_bcd_lab.sv

/* bcd_lab_trace.txt */
# rate_sel dir_a dir_b op cycles exp_a exp_b   (all decimal, dir 1 counts up)
# op 0 add, 1 sub, 2 mul, 3 max; exp_a and exp_b are the digits after the step
# A up, B down from zero, B wraps 0 to 9
0 1 0 0 10 5 5
0 1 0 1 8 9 1
# Rate 1, A wraps 9 to 0, then 3*7
1 1 0 2 14 3 7
# Rate 3 with no tick yet, 3-7 is negative
3 1 0 1 10 3 7
# Directions swap, zero product
3 0 1 2 46 0 0
1 0 1 3 6 8 2
# 5-5 gives zero, then 9*9
0 0 1 1 6 5 5
1 1 1 2 14 9 9
3 0 1 0 30 7 1
0 1 0 1 7 0 8
